//--- logic/input_pkg.sv
package input_pkg;

	// ============================================================
	// Keyboard scan codes (set 2 make codes)
	// ============================================================
	typedef enum logic [7:0] {
		SC_START1  = 8'h16,  // Key 1
		SC_START2  = 8'h1E,  // Key 2
		SC_COIN1   = 8'h2E,  // Key 5
		SC_COIN2   = 8'h36,  // Key 6
		SC_SERVICE = 8'h46,  // Key 9
		SC_FAST    = 8'h11,  // Alt
		SC_LEFT    = 8'h6B,  // Cursor left
		SC_RIGHT   = 8'h74,  // Cursor right
		SC_FIRE    = 8'h29   // Space bar
	} scan_code_t;

	// Joystick bus layout
	localparam int JOY_W      = 9;
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_FIRE   = 4;
	localparam int JOY_FAST   = 5;
	localparam int JOY_START1 = 6;
	localparam int JOY_COIN1  = 7;
	localparam int JOY_START2 = 8;

	// Host event words
	localparam int KEY_W   = 11;  // Toggle, pressed, extended, code
	localparam int MOUSE_W = 25;  // Toggle on top bit

	// Cabinet option bits
	localparam int OPT_W = 8;

endpackage

//--- logic/spinner_pkg.sv
package spinner_pkg;

	// ============================================================
	// Quadrature encoder states in Gray order
	// ============================================================
	typedef enum logic [1:0] {
		Q00 = 2'b00,
		Q01 = 2'b01,
		Q11 = 2'b11,
		Q10 = 2'b10
	} quad_t;

	// Idle level of both encoder lines
	localparam quad_t QUAD_RESET = Q11;

	// Signed travel accumulator
	localparam int POS_W = 12;

	// Ticks between drained steps, 6 MHz tick gives 4 kHz
	localparam int STEP_DIV = 1500;
	localparam int DIV_W    = $clog2(STEP_DIV);

	// D-pad poll period in ticks
	// Roughly 8 ms, same rate as a standard mouse poll
	localparam int POLL_TICKS = 48000;
	localparam int POLL_W     = $clog2(POLL_TICKS);

	// Travel loaded per poll
	localparam int DPAD_SLOW = 4;
	localparam int DPAD_FAST = 9;

endpackage

//--- logic/button_decode.sv
`timescale 1ns/1ps

module button_decode (
	input  logic                        CLK_12M,
	input  logic                        rst_n,
	input  logic [input_pkg::KEY_W-1:0] ps2_key,
	input  logic [1:0]                  mouse_btn,
	input  logic [input_pkg::JOY_W-1:0] joy,
	input  logic                        fire_ext_n,
	input  logic [input_pkg::OPT_W-1:0] options,
	output logic                        shot_n,
	output logic                        coin1_n,
	output logic                        coin2_n,
	output logic                        start1_n,
	output logic                        start2_n,
	output logic                        service_n,
	output logic [input_pkg::OPT_W-1:0] dip_sw,
	output logic                        spin_fast,
	output logic                        spin_left,
	output logic                        spin_right
);
	import input_pkg::*;

	logic       key_tgl_q;                          // Last seen toggle bit
	logic       key_evt;
	logic       key_down;
	scan_code_t key_code;

	// Held keys and their next values
	logic h_start1, h_start2, h_coin1, h_coin2, h_service;
	logic h_fast, h_left, h_right, h_fire;
	logic k_start1, k_start2, k_coin1, k_coin2, k_service;
	logic k_fast, k_left, k_right, k_fire;

	assign key_evt  = ps2_key[KEY_W-1] != key_tgl_q;
	assign key_down = ps2_key[9];
	assign key_code = scan_code_t'(ps2_key[7:0]);

	// ============================================================
	// Key table, unknown codes fall through untouched
	// ============================================================
	always_comb begin
		k_start1  = h_start1;
		k_start2  = h_start2;
		k_coin1   = h_coin1;
		k_coin2   = h_coin2;
		k_service = h_service;
		k_fast    = h_fast;
		k_left    = h_left;
		k_right   = h_right;
		k_fire    = h_fire;
		if (key_evt) begin
			case (key_code)
				SC_START1:  k_start1  = key_down;
				SC_START2:  k_start2  = key_down;
				SC_COIN1:   k_coin1   = key_down;
				SC_COIN2:   k_coin2   = key_down;
				SC_SERVICE: k_service = key_down;
				SC_FAST:    k_fast    = key_down;
				SC_LEFT:    k_left    = key_down;
				SC_RIGHT:   k_right   = key_down;
				SC_FIRE:    k_fire    = key_down;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			key_tgl_q  <= 1'b0;
			{h_start1, h_start2, h_coin1, h_coin2, h_service} <= '0;
			{h_fast, h_left, h_right, h_fire} <= '0;
			{shot_n, coin1_n, coin2_n, start1_n, start2_n, service_n} <= '1;  // All released
			{spin_fast, spin_left, spin_right} <= '0;
		end else begin
			key_tgl_q <= ps2_key[KEY_W-1];
			{h_start1, h_start2, h_coin1, h_coin2, h_service} <=
				{k_start1, k_start2, k_coin1, k_coin2, k_service};
			{h_fast, h_left, h_right, h_fire} <= {k_fast, k_left, k_right, k_fire};
			// Merge sources, game core wants active low
			shot_n     <= ~(k_fire | joy[JOY_FIRE] | (|mouse_btn) | ~fire_ext_n);
			coin1_n    <= ~(k_coin1 | joy[JOY_COIN1]);
			coin2_n    <= ~k_coin2;                 // Keyboard only
			start1_n   <= ~(k_start1 | joy[JOY_START1]);
			start2_n   <= ~(k_start2 | joy[JOY_START2]);
			service_n  <= ~k_service;
			spin_fast  <= k_fast | joy[JOY_FAST];
			spin_left  <= k_left | joy[JOY_LEFT];
			spin_right <= k_right | joy[JOY_RIGHT];
		end
	end

	// Cabinet bit stays as is, the rest are active low switches
	assign dip_sw = {options[OPT_W-1], ~options[OPT_W-2:0]};

endmodule

//--- logic/quad_stepper.sv
`timescale 1ns/1ps

module quad_stepper (
	input  logic               CLK_12M,
	input  logic               rst_n,
	input  logic               step,   // One cycle strobe
	input  logic               dir,    // 1 forward
	output spinner_pkg::quad_t state
);
	import spinner_pkg::*;

	quad_t state_nx;

	// Forward walks 00 01 11 10, reverse walks it backwards
	always_comb begin
		case ({dir, state})
			{1'b1, Q00}: state_nx = Q01;
			{1'b1, Q01}: state_nx = Q11;
			{1'b1, Q11}: state_nx = Q10;
			{1'b1, Q10}: state_nx = Q00;
			{1'b0, Q00}: state_nx = Q10;
			{1'b0, Q10}: state_nx = Q11;
			{1'b0, Q11}: state_nx = Q01;
			default:     state_nx = Q00;  // Reverse from Q01
		endcase
	end

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			state <= QUAD_RESET;
		end else if (step) begin
			state <= state_nx;
		end
	end

endmodule

//--- logic/spinner_position.sv
`timescale 1ns/1ps

module spinner_position (
	input  logic                          CLK_12M,
	input  logic                          rst_n,
	input  logic [input_pkg::MOUSE_W-1:0] ps2_mouse,
	input  logic                          spin_fast,
	input  logic                          spin_left,
	input  logic                          spin_right,
	output logic                          emu_step,
	output logic                          emu_dir,
	output logic                          emu_active
);
	import spinner_pkg::*;

	logic                    tick;        // Every second clock
	logic [DIV_W-1:0]        div_cnt;     // Drain rate divider
	logic [POLL_W-1:0]       poll_cnt;    // D-pad poll timer
	logic signed [POS_W-1:0] pos;         // Travel still owed to the encoder
	logic signed [POS_W-1:0] pos_nx;
	logic signed [POS_W-1:0] delta;
	logic signed [POS_W-1:0] dpad_pos;
	logic                    mouse_tgl_q;
	logic                    mouse_evt;
	logic                    mouse_ok;
	logic                    dpad;
	logic                    step_now;
	logic                    poll_hit;

	// ============================================================
	// Event decode
	// ============================================================
	assign mouse_evt = ps2_mouse[input_pkg::MOUSE_W-1] != mouse_tgl_q;
	// Guard against overflow when the top two bits disagree
	assign mouse_ok  = mouse_evt && (pos[POS_W-1] == pos[POS_W-2]);
	// X magnitude with its sign bit, widened to the accumulator
	assign delta     = {{(POS_W-8){ps2_mouse[4]}}, ps2_mouse[15:8]};
	assign dpad      = spin_left | spin_right;

	assign step_now  = tick && (div_cnt == '0) && (pos != '0);
	assign poll_hit  = tick && dpad && !mouse_evt
		&& (poll_cnt == POLL_W'(POLL_TICKS - 1));

	// Right spins positive
	always_comb begin
		if (spin_right) begin
			dpad_pos = spin_fast ? POS_W'(DPAD_FAST) : POS_W'(DPAD_SLOW);
		end else begin
			dpad_pos = spin_fast ? POS_W'(-DPAD_FAST) : POS_W'(-DPAD_SLOW);
		end
	end

	always_comb begin
		pos_nx = pos;
		if (step_now) begin
			// One unit toward zero
			pos_nx = pos[POS_W-1] ? pos + POS_W'(1) : pos - POS_W'(1);
		end
		if (mouse_ok) begin
			pos_nx = pos_nx + delta;
		end
		if (poll_hit) begin
			pos_nx = dpad_pos;                  // Poll reloads, no accumulation
		end
	end

	// ============================================================
	// State
	// ============================================================
	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			tick        <= 1'b0;
			div_cnt     <= '0;
			poll_cnt    <= '0;
			pos         <= '0;
			mouse_tgl_q <= 1'b0;
			emu_step    <= 1'b0;
			emu_dir     <= 1'b0;
			emu_active  <= 1'b0;
		end else begin
			tick        <= ~tick;
			mouse_tgl_q <= ps2_mouse[input_pkg::MOUSE_W-1];
			if (tick) begin
				div_cnt <= (div_cnt == DIV_W'(STEP_DIV - 1)) ? '0 : div_cnt + 1'b1;
			end
			if (!dpad) begin
				poll_cnt <= '0;                 // Restart on release
			end else if (tick && !mouse_evt) begin
				poll_cnt <= poll_hit ? '0 : poll_cnt + 1'b1;
			end
			pos        <= pos_nx;
			emu_step   <= step_now;
			emu_dir    <= pos[POS_W-1];         // Negative travel runs forward
			emu_active <= mouse_evt || (tick && dpad);
		end
	end

endmodule

//--- logic/spinner_select.sv
`timescale 1ns/1ps

module spinner_select (
	input  logic               CLK_12M,
	input  logic               rst_n,
	input  logic [1:0]         enc_in,      // Physical encoder, A on bit 0
	input  logic               emu_active,
	input  spinner_pkg::quad_t emu_state,
	input  spinner_pkg::quad_t raw_state,
	output logic               raw_step,
	output logic               raw_dir,
	output logic [1:0]         spinner
);
	import spinner_pkg::*;

	logic [1:0] enc_s1;
	logic [1:0] enc_s2;     // Synchronized pair
	logic [1:0] enc_q;      // Previous synchronized pair
	logic [2:0] sync_fill;  // Set once all three stages hold real samples
	logic       use_raw;
	logic       enc_move;

	// ============================================================
	// Encoder synchronizer and edge detect
	// ============================================================
	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			enc_s1    <= '0;
			enc_s2    <= '0;
			enc_q     <= '0;
			sync_fill <= '0;
		end else begin
			enc_s1    <= enc_in;
			enc_s2    <= enc_s1;
			enc_q     <= enc_s2;
			sync_fill <= {sync_fill[1:0], 1'b1};
		end
	end

	assign enc_move = sync_fill[2] && (enc_s2 != enc_q);
	assign raw_step = sync_fill[2] && (enc_s2[0] != enc_q[0]);  // Each A edge
	assign raw_dir  = enc_s2[0] ^ enc_s2[1];                     // A != B is forward

	// Physical source wins a same-cycle tie
	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			use_raw <= 1'b0;
		end else if (enc_move) begin
			use_raw <= 1'b1;
		end else if (emu_active) begin
			use_raw <= 1'b0;
		end
	end

	assign spinner = use_raw ? raw_state : emu_state;

endmodule

//--- logic/arkanoid_controls.sv
`timescale 1ns/1ps

module arkanoid_controls (
	input  logic                          CLK_12M,
	input  logic                          rst_n,
	input  logic [input_pkg::KEY_W-1:0]   ps2_key,
	input  logic [input_pkg::MOUSE_W-1:0] ps2_mouse,
	input  logic [input_pkg::JOY_W-1:0]   joy,
	input  logic [1:0]                    enc_in,
	input  logic                          fire_ext_n,
	input  logic [input_pkg::OPT_W-1:0]   options,
	output logic [1:0]                    spinner,
	output logic                          shot_n,
	output logic                          coin1_n,
	output logic                          coin2_n,
	output logic                          start1_n,
	output logic                          start2_n,
	output logic                          service_n,
	output logic [input_pkg::OPT_W-1:0]   dip_sw
);
	import spinner_pkg::*;

	logic  spin_fast, spin_left, spin_right;  // D-pad requests
	logic  emu_step, emu_dir, emu_active;
	logic  raw_step, raw_dir;
	quad_t emu_state;
	quad_t raw_state;

	// ============================================================
	// Buttons and DIP switches
	// ============================================================
	button_decode u_decode (
		.CLK_12M, .rst_n, .ps2_key, .mouse_btn(ps2_mouse[1:0]), .joy, .fire_ext_n,
		.options, .shot_n, .coin1_n, .coin2_n, .start1_n, .start2_n, .service_n,
		.dip_sw, .spin_fast, .spin_left, .spin_right
	);

	// ============================================================
	// Spinner path
	// ============================================================
	spinner_position u_position (
		.CLK_12M, .rst_n, .ps2_mouse, .spin_fast, .spin_left, .spin_right,
		.emu_step, .emu_dir, .emu_active
	);

	// Emulated encoder
	quad_stepper emu_quad (
		.CLK_12M, .rst_n, .step(emu_step), .dir(emu_dir), .state(emu_state)
	);

	// Physical encoder regenerated at the game clock
	quad_stepper raw_quad (
		.CLK_12M, .rst_n, .step(raw_step), .dir(raw_dir), .state(raw_state)
	);

	spinner_select u_select (
		.CLK_12M, .rst_n, .enc_in, .emu_active, .emu_state, .raw_state,
		.raw_step, .raw_dir, .spinner
	);

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic CLK_12M,
	output logic rst_n
);

	initial begin
		CLK_12M = 1'b0;
		forever #2 CLK_12M = ~CLK_12M;      // 4 ns period
	end

	// Reset held 16 clocks, let go on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge CLK_12M);
		@(negedge CLK_12M);
		rst_n = 1'b1;
	end

endmodule

//--- dv/tb_arkanoid_controls.sv
`timescale 1ns/1ps

module tb_arkanoid_controls;
	import input_pkg::*;
	import spinner_pkg::*;

	localparam int TIMEOUT = 200000;
	localparam int QUIET   = 10000;        // Still window after a spin

	typedef enum logic [2:0] {
		RK_KEY, RK_JOY, RK_MBTN, RK_FIRE, RK_OPT, RK_ENC, RK_MOUSE, RK_DPAD
	} row_kind_t;

	typedef struct packed {
		row_kind_t   kind;
		logic [15:0] data;                  // Stimulus word
		logic [15:0] exp_val;               // Buttons over DIP, or transition count
		logic        fwd;                   // Expected spinner direction
	} row_t;

	logic               CLK_12M;
	logic               rst_n;
	logic [KEY_W-1:0]   ps2_key;
	logic [MOUSE_W-1:0] ps2_mouse;
	logic [JOY_W-1:0]   joy;
	logic [1:0]         enc_in;           // A on bit 0
	logic               fire_ext_n;
	logic [OPT_W-1:0]   options;
	logic [1:0]         spinner;
	logic               shot_n, coin1_n, coin2_n, start1_n, start2_n, service_n;
	logic [OPT_W-1:0]   dip_sw;

	row_t       rows[$];
	logic [1:0] prev_spin;
	int         fwd_cnt = 0;
	int         rev_cnt = 0;
	int         base_f;
	int         base_r;
	// Index matches the bit in {shot_n .. service_n}
	scan_code_t key_codes [6] = '{SC_SERVICE, SC_START2, SC_START1, SC_COIN2, SC_COIN1, SC_FIRE};

	clock_gen u_clk (.CLK_12M, .rst_n);

	arkanoid_controls dut (.*);

	// ============================================================
	// Helpers
	// ============================================================
	task automatic report_failure(string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_val(string name, logic [15:0] got, logic [15:0] exp);
		assert (got === exp) else
			report_failure($sformatf("MISMATCH time=%0t %s expected=%0h got=%0h",
				$time, name, exp, got));
	endtask

	// Forward Gray order 00 01 11 10
	function automatic logic [1:0] fwd_next(logic [1:0] s);
		case (s)
			2'b00:   return 2'b01;
			2'b01:   return 2'b11;
			2'b11:   return 2'b10;
			default: return 2'b00;
		endcase
	endfunction

	// Button word with one line low, -1 for none, DIP byte of options 0
	function automatic logic [15:0] btn_word(int low);
		logic [5:0] b;
		b = 6'h3F;
		if (low >= 0)
			b[low] = 1'b0;
		return {2'b00, b, 8'h7F};
	endfunction

	function automatic void add_row(row_kind_t kind, logic [15:0] data, logic [15:0] exp_val,
		logic fwd);
		row_t r;
		r = '{kind, data, exp_val, fwd};
		rows.push_back(r);
	endfunction

	// Spinner monitor, sampled on the falling edge where outputs are settled
	always @(negedge CLK_12M) begin
		if (rst_n && spinner !== prev_spin) begin
			assert (fwd_next(prev_spin) == spinner || fwd_next(spinner) == prev_spin) else
				report_failure($sformatf("spinner jumped from %b to %b, not one quadrature step",
					prev_spin, spinner));
			if (fwd_next(prev_spin) == spinner)
				fwd_cnt++;
			else
				rev_cnt++;
		end
		prev_spin = spinner;
	end

	task automatic wait_reset();
		int n;
		n = 0;
		while (!rst_n) begin
			@(posedge CLK_12M);
			n++;
			assert (n < TIMEOUT) else report_failure("reset was never released");
		end
	endtask

	// Counters move on the falling edge, so read them on the rising one
	task automatic take_snapshot();
		@(posedge CLK_12M);
		base_f = fwd_cnt;
		base_r = rev_cnt;
	endtask

	task automatic wait_count(logic fwd, int target);
		int n;
		n = 0;
		do begin
			@(posedge CLK_12M);
			n++;
			assert (n < TIMEOUT) else
				report_failure($sformatf("timeout waiting for %0d %s spinner transitions",
					target, fwd ? "forward" : "reverse"));
		end while ((fwd ? fwd_cnt : rev_cnt) < target);
	endtask

	// Wait until no transition for a full quiet window
	task automatic wait_still();
		int n;
		int quiet;
		int last;
		n = 0;
		quiet = 0;
		last = -1;
		while (quiet < QUIET) begin
			@(posedge CLK_12M);
			n++;
			assert (n < TIMEOUT) else report_failure("timeout waiting for the spinner to rest");
			if (fwd_cnt + rev_cnt != last) begin
				last = fwd_cnt + rev_cnt;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic check_counts(logic fwd, int count);
		@(posedge CLK_12M);
		check_val("spinner forward count", fwd_cnt - base_f, fwd ? count : 0);
		check_val("spinner reverse count", rev_cnt - base_r, fwd ? 0 : count);
	endtask

	task automatic check_buttons(logic [15:0] exp);
		check_val("shot_n..service_n", {shot_n, coin1_n, coin2_n, start1_n, start2_n, service_n},
			exp[13:8]);
		check_val("dip_sw", dip_sw, exp[7:0]);
	endtask

	task automatic send_key(logic pressed, logic [7:0] code);
		@(negedge CLK_12M);
		ps2_key = {~ps2_key[KEY_W-1], pressed, 1'b0, code};   // Toggle marks the event
	endtask

	task automatic send_mouse(logic [15:0] delta);
		@(negedge CLK_12M);
		ps2_mouse = {~ps2_mouse[MOUSE_W-1], 8'h00, delta[7:0], 3'b000, delta[15], 2'b00,
			ps2_mouse[1:0]};
	endtask

	// B set first, so the A edge reads forward when new A differs from B
	task automatic enc_edge(logic fwd);
		@(negedge CLK_12M);
		enc_in[1] = fwd ? enc_in[0] : ~enc_in[0];
		repeat (4) @(negedge CLK_12M);      // Let B through the synchronizer
		enc_in[0] = ~enc_in[0];
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================
	task automatic build_table();
		int mag;
		for (int i = 0; i < 6; i++) begin
			add_row(RK_KEY, {7'd0, 1'b1, key_codes[i]}, btn_word(i), 1'b0);
			add_row(RK_KEY, {7'd0, 1'b0, key_codes[i]}, btn_word(-1), 1'b0);
		end
		add_row(RK_KEY, 16'h0155, btn_word(-1), 1'b0);     // Unknown code
		add_row(RK_JOY, 16'(1 << JOY_FIRE), btn_word(5), 1'b0);
		add_row(RK_JOY, 16'(1 << JOY_COIN1), btn_word(4), 1'b0);
		add_row(RK_JOY, 16'(1 << JOY_START1), btn_word(2), 1'b0);
		add_row(RK_JOY, 16'(1 << JOY_START2), btn_word(1), 1'b0);
		add_row(RK_JOY, 16'h0000, btn_word(-1), 1'b0);
		add_row(RK_MBTN, 16'h0001, btn_word(5), 1'b0);
		add_row(RK_MBTN, 16'h0002, btn_word(5), 1'b0);
		add_row(RK_MBTN, 16'h0000, btn_word(-1), 1'b0);
		add_row(RK_FIRE, 16'h0000, btn_word(5), 1'b0);
		add_row(RK_FIRE, 16'h0001, btn_word(-1), 1'b0);
		add_row(RK_OPT, 16'h00A5, 16'h3FDA, 1'b0);         // Cabinet bit kept, rest inverted
		add_row(RK_OPT, 16'h003C, 16'h3F43, 1'b0);
		add_row(RK_OPT, 16'h0000, 16'h3F7F, 1'b0);
		// Equal edges each way bring the raw stepper back to Q11
		add_row(RK_ENC, 16'd4, 16'd4, 1'b1);
		add_row(RK_ENC, 16'd4, 16'd4, 1'b0);
		add_row(RK_MOUSE, 16'd5, 16'd5, 1'b0);            // Hands back to emulation
		add_row(RK_MOUSE, -16'sd5, 16'd5, 1'b1);
		add_row(RK_MOUSE, 16'd1, 16'd1, 1'b0);
		add_row(RK_MOUSE, -16'sd12, 16'd12, 1'b1);
		for (int i = 0; i < 3; i++) begin
			mag = 1 + int'($urandom % 20);
			add_row(RK_MOUSE, i[0] ? 16'(-mag) : 16'(mag), 16'(mag), i[0]);
		end
		add_row(RK_DPAD, 16'd1, 16'(DPAD_FAST), 1'b0);    // Right with fast
		add_row(RK_DPAD, 16'd0, 16'(DPAD_SLOW), 1'b1);    // Left alone
	endtask

	task automatic apply_row(row_t r);
		case (r.kind)
			RK_KEY, RK_JOY, RK_MBTN, RK_FIRE, RK_OPT: begin
				@(negedge CLK_12M);
				case (r.kind)
					RK_KEY:  ps2_key = {~ps2_key[KEY_W-1], r.data[8], 1'b0, r.data[7:0]};
					RK_JOY:  joy = r.data[JOY_W-1:0];
					RK_MBTN: ps2_mouse[1:0] = r.data[1:0];
					RK_FIRE: fire_ext_n = r.data[0];
					default: options = r.data[OPT_W-1:0];
				endcase
				@(negedge CLK_12M);                 // One clock of latency
				check_buttons(r.exp_val);
			end
			RK_ENC: begin
				take_snapshot();
				for (int k = 1; k <= int'(r.data); k++) begin
					enc_edge(r.fwd);
					wait_count(r.fwd, (r.fwd ? base_f : base_r) + k);
				end
				check_counts(r.fwd, r.exp_val);
			end
			RK_MOUSE: begin
				take_snapshot();
				send_mouse(r.data);
				wait_count(r.fwd, (r.fwd ? base_f : base_r) + r.exp_val);
				repeat (QUIET) @(posedge CLK_12M);
				check_counts(r.fwd, r.exp_val);    // Exact, nothing extra
			end
			default: begin
				take_snapshot();
				if (r.data[0])
					send_key(1'b1, SC_FAST);
				send_key(1'b1, r.fwd ? SC_LEFT : SC_RIGHT);
				wait_count(r.fwd, (r.fwd ? base_f : base_r) + r.exp_val);
				send_key(1'b0, r.fwd ? SC_LEFT : SC_RIGHT);
				send_key(1'b0, SC_FAST);
				wait_still();
				@(posedge CLK_12M);
				check_val(r.fwd ? "spinner reverse count" : "spinner forward count",
					r.fwd ? rev_cnt - base_r : fwd_cnt - base_f, 16'd0);
			end
		endcase
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		ps2_key    = '0;
		ps2_mouse  = '0;
		joy        = '0;
		enc_in     = 2'b00;
		fire_ext_n = 1'b1;
		options    = '0;
		void'($urandom(51032));
		build_table();
		wait_reset();
		@(negedge CLK_12M);
		check_buttons(btn_word(-1));
		check_val("spinner", spinner, Q11);
		take_snapshot();
		repeat (QUIET) @(posedge CLK_12M);
		check_counts(1'b0, 0);                  // Idle after reset
		foreach (rows[i])
			apply_row(rows[i]);
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- build.f
logic/input_pkg.sv
logic/spinner_pkg.sv
logic/button_decode.sv
logic/quad_stepper.sv
logic/spinner_position.sv
logic/spinner_select.sv
logic/arkanoid_controls.sv
dv/clock_gen.sv
dv/tb_arkanoid_controls.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench, exit status follows the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_arkanoid_controls -f build.f -Mdir obj_dir
./obj_dir/Vtb_arkanoid_controls
